// ==== sources.f ====
risk_pkg.sv
order_intake.sv
command_fifo.sv
client_ledger.sv
risk_engine.sv
risk_top.sv
risk_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the risk gate testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module risk_tb \
  -f sources.f --Mdir obj_dir -o risk_sim

./obj_dir/risk_sim > sim.log
cat sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== risk_tb.sv ====
// risk gate testbench
// directed tests against a per-client reference model
// expected results are queued in push order and compared as they leave the engine
`timescale 1ns/1ps

module risk_tb;

  localparam int NUM_DIRECTED = 13; // tests 1 to 4
  localparam int NUM_RANDOM   = 60;
  localparam int NUM_BURST    = 16; // 8 collisions of two pushes
  localparam int NUM_CMDS     = NUM_DIRECTED + NUM_RANDOM + NUM_BURST;
  localparam int TIMEOUT_NS   = NUM_CMDS * 200 + 2000;

  logic                     clk;
  logic                     rst_n;
  logic                     cpu_go;
  logic                     cpu_new_max;
  risk_pkg::client_id_t     cpu_client_id;
  risk_pkg::amount_t        cpu_amount;
  logic                     exchange_go;
  risk_pkg::client_id_t     exchange_client_id;
  risk_pkg::cancel_amount_t exchange_amount;
  logic                     result_valid;
  risk_pkg::risk_result_t   result;
  logic                     overflow;

  risk_pkg::amount_t        m_max [32]; // model ledger
  risk_pkg::amount_t        m_acc [32];
  risk_pkg::cancel_amount_t m_cxl [32];
  risk_pkg::risk_result_t   exp_q [$];  // expected results, push order
  int                       errors;
  bit                       check_on;   // off while the burst floods the queue

  risk_top #(.FIFO_DEPTH(4)) UUT (
    .clk(clk), .rst_n(rst_n),
    .cpu_go(cpu_go), .cpu_new_max(cpu_new_max),
    .cpu_client_id(cpu_client_id), .cpu_amount(cpu_amount),
    .exchange_go(exchange_go), .exchange_client_id(exchange_client_id),
    .exchange_amount(exchange_amount),
    .result_valid(result_valid), .result(result), .overflow(overflow)
  );

  initial
    clk = 1'b0;
  always #5 clk = ~clk; // 10 ns period

  // accept when acc + amount - cancelled stays within the limit
  function automatic risk_pkg::risk_result_t model_step(input risk_pkg::cmd_kind_t kind,
      input risk_pkg::client_id_t client, input risk_pkg::amount_t amount);
    risk_pkg::risk_result_t r;
    logic [33:0]            total;
    total = 34'(m_acc[client]) + 34'(amount);
    if (total > 34'(m_cxl[client]))
      total = total - 34'(m_cxl[client]);
    else
      total = '0; // cancels cannot make exposure negative
    r.kind     = kind;
    r.client   = client;
    r.accepted = 1'b1;
    case (kind)
      risk_pkg::cmd_order:
      begin
        r.accepted = (total <= 34'(m_max[client]));
        if (r.accepted)
          m_acc[client] = m_acc[client] + amount;
      end
      risk_pkg::cmd_new_max: m_max[client] = amount;
      default:               m_cxl[client] = m_cxl[client] + amount[15:0]; // wraps at 16 bits
    endcase
    r.accumulated = m_acc[client];
    r.cancelled   = m_cxl[client];
    return r;
  endfunction

  task automatic check_result(input risk_pkg::risk_result_t got,
                              input risk_pkg::risk_result_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t: client %0d %s got ok=%0b acc=%0d cxl=%0d", $time, exp.client,
               exp.kind.name(), got.accepted, got.accumulated, got.cancelled);
      $display("  expected client %0d ok=%0b acc=%0d cxl=%0d (engine in %s)", exp.client,
               exp.accepted, exp.accumulated, exp.cancelled, UUT.u_engine.state.name());
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // result monitor on the falling edge
  always @(negedge clk)
  begin
    if (rst_n && check_on && result_valid)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("the DUT produced a result at %0t with no command outstanding", $time);
      end
      else
        check_result(result, exp_q.pop_front());
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("test failed");
    $finish;
  end

  task automatic apply_reset();
    rst_n = 1'b0;
    exp_q.delete();
    for (int i = 0; i < 32; i++)
    begin
      m_max[i] = '0;
      m_acc[i] = '0;
      m_cxl[i] = '0;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic send_cpu(input logic new_max, input risk_pkg::client_id_t client,
                          input risk_pkg::amount_t amount, input int gap);
    @(negedge clk);
    cpu_go        = 1'b1;
    cpu_new_max   = new_max;
    cpu_client_id = client;
    cpu_amount    = amount;
    exp_q.push_back(model_step(new_max ? risk_pkg::cmd_new_max : risk_pkg::cmd_order,
                               client, amount));
    @(negedge clk);
    cpu_go = 1'b0;
    repeat (gap) @(negedge clk);
  endtask

  task automatic send_cancel(input risk_pkg::client_id_t client,
                             input risk_pkg::cancel_amount_t amount, input int gap);
    @(negedge clk);
    exchange_go        = 1'b1;
    exchange_client_id = client;
    exchange_amount    = amount;
    exp_q.push_back(model_step(risk_pkg::cmd_cancel, client, risk_pkg::amount_t'(amount)));
    @(negedge clk);
    exchange_go = 1'b0;
    repeat (gap) @(negedge clk);
  endtask

  task automatic send_both(input logic new_max, input risk_pkg::client_id_t cpu_client,
                           input risk_pkg::amount_t amount, input risk_pkg::client_id_t x_client,
                           input risk_pkg::cancel_amount_t x_amount);
    @(negedge clk);
    cpu_go             = 1'b1;
    cpu_new_max        = new_max;
    cpu_client_id      = cpu_client;
    cpu_amount         = amount;
    exchange_go        = 1'b1;
    exchange_client_id = x_client;
    exchange_amount    = x_amount;
    exp_q.push_back(model_step(risk_pkg::cmd_cancel, x_client, risk_pkg::amount_t'(x_amount)));
    exp_q.push_back(model_step(new_max ? risk_pkg::cmd_new_max : risk_pkg::cmd_order,
                               cpu_client, amount)); // cpu side lands second
    @(negedge clk);
    cpu_go      = 1'b0;
    exchange_go = 1'b0;
    repeat (4) @(negedge clk);
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  task automatic first_limit_orders();
    send_cpu(1'b0, 5'd3, 32'd100, 4);  // no limit yet so rejected
    send_cpu(1'b1, 5'd3, 32'd500, 4);
    send_cpu(1'b0, 5'd3, 32'd200, 4);  // within limit
    drain();
  endtask

  task automatic limit_edge_orders();
    send_cpu(1'b1, 5'd7, 32'd1000, 4);
    send_cpu(1'b0, 5'd7, 32'd600, 4);
    send_cpu(1'b0, 5'd7, 32'd500, 4);  // 1100 over limit
    send_cpu(1'b0, 5'd7, 32'd400, 4);  // exactly 1000
    drain();
  endtask

  task automatic cancel_relief();
    send_cpu(1'b0, 5'd7, 32'd500, 4);  // still rejected
    send_cancel(5'd7, 16'd500, 4);
    send_cpu(1'b0, 5'd7, 32'd500, 4);  // exposure back at limit
    drain();
  endtask

  task automatic strobe_collision();
    send_both(1'b1, 5'd9, 32'd2000, 5'd9, 16'd50);
    send_cpu(1'b0, 5'd9, 32'd2040, 4); // needs both the limit and the cancel
    drain();
  endtask

  task automatic random_traffic();
    int                   pick;
    risk_pkg::client_id_t client;
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      pick   = $urandom_range(0, 9);
      client = risk_pkg::client_id_t'($urandom_range(16, 21));
      if (pick < 2)
        send_cpu(1'b1, client, $urandom_range(0, 4000), $urandom_range(2, 4));
      else if (pick < 7)
        send_cpu(1'b0, client, $urandom_range(1, 600), $urandom_range(2, 4));
      else
        send_cancel(client, 16'($urandom_range(0, 400)), $urandom_range(2, 4));
    end
    drain();
    check_flag(overflow, 1'b0, "overflow after spaced traffic");
  endtask

  task automatic burst_overflow();
    check_on = 1'b0; // dropped commands leave the model behind
    for (int i = 0; i < NUM_BURST / 2; i++)
    begin
      @(negedge clk);
      cpu_go             = 1'b1;
      cpu_new_max        = 1'b0;
      cpu_client_id      = 5'd1;
      cpu_amount         = 32'd10;
      exchange_go        = 1'b1;
      exchange_client_id = 5'd1;
      exchange_amount    = 16'd5;
      @(negedge clk);
      cpu_go      = 1'b0;
      exchange_go = 1'b0;
    end
    repeat (4) @(negedge clk);
    check_flag(overflow, 1'b1, "overflow after burst");
    apply_reset();
    @(negedge clk);
    check_flag(overflow, 1'b0, "overflow after fresh reset");
    check_on = 1'b1;
  endtask

  initial
  begin
    rst_n              = 1'b0;
    cpu_go             = 1'b0;
    cpu_new_max        = 1'b0;
    cpu_client_id      = '0;
    cpu_amount         = '0;
    exchange_go        = 1'b0;
    exchange_client_id = '0;
    exchange_amount    = '0;
    errors             = 0;
    check_on           = 1'b1;
    void'($urandom(92)); // one seed for the whole run
    apply_reset();
    first_limit_orders();
    limit_edge_orders();
    cancel_relief();
    strobe_collision();
    random_traffic();
    burst_overflow();
    $display("run complete, %0d errors", errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== risk_top.sv ====
// pre-trade risk gate top level
// cpu and exchange strobes feed the intake, the queue buffers commands
// and the engine checks each one against the client ledger
`timescale 1ns/1ps

module risk_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cpu_go,
  input  logic                     cpu_new_max,
  input  risk_pkg::client_id_t     cpu_client_id,
  input  risk_pkg::amount_t        cpu_amount,
  input  logic                     exchange_go,
  input  risk_pkg::client_id_t     exchange_client_id,
  input  risk_pkg::cancel_amount_t exchange_amount,
  output logic                     result_valid,
  output risk_pkg::risk_result_t   result,
  output logic                     overflow
);

  logic                     push;
  logic                     pop;
  logic                     empty;
  risk_pkg::risk_cmd_t      cmd;
  risk_pkg::risk_cmd_t      head;
  risk_pkg::client_id_t     rd_client;
  risk_pkg::amount_t        rd_max;
  risk_pkg::amount_t        rd_accumulated;
  risk_pkg::cancel_amount_t rd_cancelled;
  logic                     wr_en;
  risk_pkg::client_id_t     wr_client;
  risk_pkg::amount_t        wr_max;
  risk_pkg::amount_t        wr_accumulated;
  risk_pkg::cancel_amount_t wr_cancelled;

  order_intake u_intake (
    .clk(clk), .rst_n(rst_n),
    .cpu_go(cpu_go), .cpu_new_max(cpu_new_max),
    .cpu_client_id(cpu_client_id), .cpu_amount(cpu_amount),
    .exchange_go(exchange_go), .exchange_client_id(exchange_client_id),
    .exchange_amount(exchange_amount),
    .push(push), .cmd(cmd)
  );

  command_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(push), .cmd(cmd), .pop(pop),
    .head(head), .empty(empty), .overflow(overflow)
  );

  risk_engine u_engine (
    .clk(clk), .rst_n(rst_n),
    .empty(empty), .head(head),
    .rd_max(rd_max), .rd_accumulated(rd_accumulated), .rd_cancelled(rd_cancelled),
    .pop(pop), .rd_client(rd_client),
    .wr_en(wr_en), .wr_client(wr_client), .wr_max(wr_max),
    .wr_accumulated(wr_accumulated), .wr_cancelled(wr_cancelled),
    .result_valid(result_valid), .result(result)
  );

  client_ledger u_ledger (
    .clk(clk), .rst_n(rst_n),
    .rd_client(rd_client),
    .wr_en(wr_en), .wr_client(wr_client), .wr_max(wr_max),
    .wr_accumulated(wr_accumulated), .wr_cancelled(wr_cancelled),
    .rd_max(rd_max), .rd_accumulated(rd_accumulated), .rd_cancelled(rd_cancelled)
  );

endmodule

// ==== risk_engine.sv ====
// risk engine
// pops one command at a time, reads the client row, applies the risk rule
// and writes the row back while pulsing the result
// an order passes when accumulated + amount - cancelled stays within the limit
`timescale 1ns/1ps

module risk_engine (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     empty,
  input  risk_pkg::risk_cmd_t      head,
  input  risk_pkg::amount_t        rd_max,
  input  risk_pkg::amount_t        rd_accumulated,
  input  risk_pkg::cancel_amount_t rd_cancelled,
  output logic                     pop,
  output risk_pkg::client_id_t     rd_client,
  output logic                     wr_en,
  output risk_pkg::client_id_t     wr_client,
  output risk_pkg::amount_t        wr_max,
  output risk_pkg::amount_t        wr_accumulated,
  output risk_pkg::cancel_amount_t wr_cancelled,
  output logic                     result_valid,
  output risk_pkg::risk_result_t   result
);

  risk_pkg::engine_state_t  state;
  risk_pkg::engine_state_t  state_next;
  risk_pkg::risk_cmd_t      cur_cmd;      // command in flight
  risk_pkg::amount_t        row_max;      // updated row
  risk_pkg::amount_t        row_acc;
  risk_pkg::cancel_amount_t row_cancel;
  logic                     row_accepted;
  logic [32:0]              order_sum;    // no wrap on the add
  logic [32:0]              exposure;
  logic                     within_limit;

  assign pop       = (state == risk_pkg::st_idle) && !empty;
  assign rd_client = cur_cmd.client; // sampled by ledger in st_read

  // exposure floored at zero and compared against the current limit
  assign order_sum    = {1'b0, rd_accumulated} + {1'b0, cur_cmd.amount};
  assign exposure     = (order_sum < 33'(rd_cancelled)) ? '0 : order_sum - 33'(rd_cancelled);
  assign within_limit = (exposure <= {1'b0, rd_max});

  always_comb
  begin
    state_next = state;
    case (state)
      risk_pkg::st_idle:   if (!empty) state_next = risk_pkg::st_read;
      risk_pkg::st_read:   state_next = risk_pkg::st_decide; // ledger read in flight
      risk_pkg::st_decide: state_next = risk_pkg::st_write;
      risk_pkg::st_write:  state_next = risk_pkg::st_idle;
      default:             state_next = risk_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= risk_pkg::st_idle;
    else
      state <= state_next;
  end

  always_ff @(posedge clk)
  begin
    if (pop)
      cur_cmd <= head; // capture head at the pop edge
    if (state == risk_pkg::st_decide)
    begin
      row_max      <= rd_max; // row unchanged by default
      row_acc      <= rd_accumulated;
      row_cancel   <= rd_cancelled;
      row_accepted <= 1'b1;
      case (cur_cmd.kind)
        risk_pkg::cmd_order:
        begin
          row_accepted <= within_limit;
          if (within_limit)
            row_acc <= order_sum[31:0];
        end
        risk_pkg::cmd_new_max: row_max <= cur_cmd.amount;
        risk_pkg::cmd_cancel:  row_cancel <= rd_cancelled + cur_cmd.amount[15:0]; // 16-bit wrap
        default:               row_accepted <= 1'b0;
      endcase
    end
  end

  assign wr_en          = (state == risk_pkg::st_write);
  assign wr_client      = cur_cmd.client;
  assign wr_max         = row_max;
  assign wr_accumulated = row_acc;
  assign wr_cancelled   = row_cancel;
  assign result_valid   = (state == risk_pkg::st_write); // one-cycle pulse

  always_comb
  begin
    result.kind        = cur_cmd.kind;
    result.client      = cur_cmd.client;
    result.accepted    = row_accepted;
    result.accumulated = row_acc; // values after the update
    result.cancelled   = row_cancel;
  end

endmodule

// ==== client_ledger.sv ====
// client ledger
// per-client limit, accumulated volume and cancelled volume
// one registered read port and one full-row write port
// everything clears on reset so all limits start at zero
`timescale 1ns/1ps

module client_ledger (
  input  logic                     clk,
  input  logic                     rst_n,
  input  risk_pkg::client_id_t     rd_client,
  input  logic                     wr_en,
  input  risk_pkg::client_id_t     wr_client,
  input  risk_pkg::amount_t        wr_max,
  input  risk_pkg::amount_t        wr_accumulated,
  input  risk_pkg::cancel_amount_t wr_cancelled,
  output risk_pkg::amount_t        rd_max,
  output risk_pkg::amount_t        rd_accumulated,
  output risk_pkg::cancel_amount_t rd_cancelled
);

  localparam int NUM_CLIENTS = 2 ** $bits(risk_pkg::client_id_t);

  risk_pkg::amount_t        max_tbl [NUM_CLIENTS]; // trading limit
  risk_pkg::amount_t        acc_tbl [NUM_CLIENTS]; // accepted order volume
  risk_pkg::cancel_amount_t cxl_tbl [NUM_CLIENTS]; // cancelled volume

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_CLIENTS; i++)
      begin
        max_tbl[i] <= '0;
        acc_tbl[i] <= '0;
        cxl_tbl[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      max_tbl[wr_client] <= wr_max; // whole row written
      acc_tbl[wr_client] <= wr_accumulated;
      cxl_tbl[wr_client] <= wr_cancelled;
    end
  end

  // read data one cycle after address
  always_ff @(posedge clk)
  begin
    rd_max         <= max_tbl[rd_client];
    rd_accumulated <= acc_tbl[rd_client];
    rd_cancelled   <= cxl_tbl[rd_client]; // old value on same-cycle write
  end

endmodule

// ==== command_fifo.sv ====
// command queue
// circular buffer of risk commands without back-pressure
// a push into a full queue is dropped and latches overflow until reset
`timescale 1ns/1ps

module command_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push,
  input  risk_pkg::risk_cmd_t cmd,
  input  logic                pop,
  output risk_pkg::risk_cmd_t head,
  output logic                empty,
  output logic                overflow
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  risk_pkg::risk_cmd_t mem [FIFO_DEPTH]; // entry storage
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                full;
  logic                do_push;
  logic                do_pop;

  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty; // pop on empty is ignored
  assign head    = mem[rd_ptr];   // head seen the cycle after push

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
      if (push && full)
        overflow <= 1'b1; // sticky
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= cmd;
  end

endmodule

// ==== order_intake.sv ====
// order intake
// merges the cpu and exchange go strobes into one registered command stream
// the exchange wins a collision and the cpu command waits one cycle
`timescale 1ns/1ps

module order_intake (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cpu_go,
  input  logic                     cpu_new_max,
  input  risk_pkg::client_id_t     cpu_client_id,
  input  risk_pkg::amount_t        cpu_amount,
  input  logic                     exchange_go,
  input  risk_pkg::client_id_t     exchange_client_id,
  input  risk_pkg::cancel_amount_t exchange_amount,
  output logic                     push,
  output risk_pkg::risk_cmd_t      cmd
);

  risk_pkg::risk_cmd_t cpu_cmd;  // command built from cpu inputs
  risk_pkg::risk_cmd_t exch_cmd; // command built from exchange inputs
  risk_pkg::risk_cmd_t hold_cmd; // parked cpu command
  logic                hold_valid;
  logic                collide;
  logic                sel_exch;
  logic                sel_hold;
  logic                sel_cpu;

  always_comb
  begin
    cpu_cmd.kind    = cpu_new_max ? risk_pkg::cmd_new_max : risk_pkg::cmd_order;
    cpu_cmd.client  = cpu_client_id;
    cpu_cmd.amount  = cpu_amount;
    exch_cmd.kind   = risk_pkg::cmd_cancel;
    exch_cmd.client = exchange_client_id;
    exch_cmd.amount = risk_pkg::amount_t'(exchange_amount); // zero extend
  end

  assign collide  = exchange_go && cpu_go;
  assign sel_exch = exchange_go;                           // exchange first
  assign sel_hold = !exchange_go && hold_valid;            // then parked cpu
  assign sel_cpu  = !exchange_go && !hold_valid && cpu_go; // plain cpu strobe

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      push       <= 1'b0;
      hold_valid <= 1'b0;
    end
    else
    begin
      push <= sel_exch || sel_hold || sel_cpu; // one cycle after go
      if (collide)
        hold_valid <= 1'b1; // park cpu side
      else if (sel_hold)
        hold_valid <= 1'b0; // issued this cycle
    end
  end

  always_ff @(posedge clk)
  begin
    if (sel_exch)
      cmd <= exch_cmd;
    else if (sel_hold)
      cmd <= hold_cmd;
    else if (sel_cpu)
      cmd <= cpu_cmd;
    if (collide)
      hold_cmd <= cpu_cmd;
  end

endmodule

// ==== risk_pkg.sv ====
// risk gate shared definitions
// command and result formats, field widths and engine states
package risk_pkg;

  typedef logic [4:0]  client_id_t;     // 32 clients
  typedef logic [31:0] amount_t;        // order and limit amounts
  typedef logic [15:0] cancel_amount_t; // exchange cancel amounts

  typedef enum logic [1:0] {
    cmd_order   = 2'd0, // cpu order
    cmd_new_max = 2'd1, // cpu limit update
    cmd_cancel  = 2'd2  // exchange cancellation
  } cmd_kind_t;

  typedef struct packed {
    cmd_kind_t  kind;
    client_id_t client;
    amount_t    amount; // cancel amount zero-extended
  } risk_cmd_t;

  typedef struct packed {
    cmd_kind_t      kind;
    client_id_t     client;
    logic           accepted;    // always set for limit and cancel
    amount_t        accumulated; // after update
    cancel_amount_t cancelled;   // after update
  } risk_result_t;

  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_read   = 2'd1,
    st_decide = 2'd2,
    st_write  = 2'd3
  } engine_state_t;

endpackage
